// File: slave_pkg.sv
`default_nettype none

package slave_pkg;

    // control frame opener sent before the slave id
    localparam logic [2:0] START_CODE = 3'b111;

    // bytes exchanged with the neighbouring boards
    localparam logic [7:0] ACK_BYTE = 8'hCC;
    localparam logic [7:0] NAK_BYTE = 8'hAA;

    // status reported to the master ahead of read data
    localparam int STATUS_BITS = 4;
    localparam logic [STATUS_BITS-1:0] ACK_NIBBLE = ACK_BYTE[7:4];
    localparam logic [STATUS_BITS-1:0] NAK_NIBBLE = NAK_BYTE[7:4];

    // transaction phase of the sequencer
    typedef enum logic [2:0] {
        IDLE,
        FRAME,
        WRITE,
        WAIT_ACK,
        READ,
        FINISH
    } seq_state_t;

endpackage

`default_nettype wire

// File: slave_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module slave_sequencer #(
    parameter int ID_WIDTH = 2,
    parameter int SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic word_full,
    input  logic streaming,
    input  logic write_done,
    input  logic read_done,
    output logic ready,
    output logic write_en,
    output logic read_en
);
    import slave_pkg::*;

    // start code, slave id, direction bit
    localparam int FRAME_LEN = 3 + ID_WIDTH + 1;
    localparam int CNT_W     = $clog2(FRAME_LEN);

    seq_state_t           state;
    logic [FRAME_LEN-2:0] frame_sr;
    logic [FRAME_LEN-1:0] frame_word;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 frame_last;
    logic                 start_ok;
    logic                 id_ok;

    // current control bit completes the frame on its last cycle
    assign frame_word = {frame_sr, control};
    assign frame_last = (bit_cnt == CNT_W'(FRAME_LEN - 1));
    assign start_ok   = (frame_word[FRAME_LEN-1 -: 3] == START_CODE);
    assign id_ok      = (frame_word[ID_WIDTH:1] == ID_WIDTH'(SLAVE_ID));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (control) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= FRAME;
                    end
                end
                FRAME: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (frame_last) begin
                        bit_cnt <= '0;
                        if (!(start_ok && id_ok))
                            state <= IDLE;
                        else if (frame_word[0])
                            state <= WRITE;
                        else
                            state <= READ;
                    end
                end
                WRITE:    if (word_full) state <= WAIT_ACK;
                WAIT_ACK: if (write_done) state <= IDLE;
                READ:     if (read_done) state <= FINISH;
                FINISH:   state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // frame bits shift in msb first
    always_ff @(posedge clk) begin
        if (state == IDLE || state == FRAME)
            frame_sr <= frame_word[FRAME_LEN-2:0];
    end

    always_comb begin
        case (state)
            IDLE, FRAME: ready = 1'b1;
            WRITE:       ready = !word_full;
            WAIT_ACK:    ready = 1'b0;
            READ:        ready = streaming;
            FINISH:      ready = 1'b0;
            default:     ready = 1'b1;
        endcase
    end

    assign write_en = (state == WRITE) || (state == WAIT_ACK);
    assign read_en  = (state == READ);

endmodule

`default_nettype wire

// File: write_path.sv
`timescale 1ns/1ns
`default_nettype none

module write_path #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  write_en,
    input  logic                  wD,
    input  logic                  valid,
    input  logic                  s_txReady,
    input  logic                  tx_resend,
    output logic                  s_txStart,
    output logic [DATA_WIDTH-1:0] s_byteForTx,
    output logic                  word_full
);
    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-2:0] word_sr;
    logic [DATA_WIDTH-1:0] word_next;
    logic                  take_bit;
    logic                  last_bit;
    logic                  launch_armed;

    assign word_next = {word_sr, wD};
    assign take_bit  = write_en && valid && !word_full;
    assign last_bit  = take_bit && (bit_cnt == CNT_W'(DATA_WIDTH - 1));

    // launch only while the transmitter can accept
    assign s_txStart = launch_armed && s_txReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            word_full <= 1'b0;
        end else if (!write_en) begin
            bit_cnt   <= '0;
            word_full <= 1'b0;
        end else if (take_bit) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit)
                word_full <= 1'b1;
        end
    end

    // shift in msb first, copy out the complete word
    always_ff @(posedge clk) begin
        if (take_bit)
            word_sr <= word_next[DATA_WIDTH-2:0];
        if (last_bit)
            s_byteForTx <= word_next;
    end

    // re-armed by the ack tracker on timeout
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            launch_armed <= 1'b0;
        else if (!write_en)
            launch_armed <= 1'b0;
        else if (last_bit || tx_resend)
            launch_armed <= 1'b1;
        else if (s_txStart)
            launch_armed <= 1'b0;
    end

endmodule

`default_nettype wire

// File: ack_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module ack_tracker #(
    parameter int DATA_WIDTH       = 32,
    parameter int ACK_TIMEOUT      = 10000,
    parameter int RETRANSMIT_TIMES = 3
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              s_txStart,
    input  logic                              s_rxDone,
    input  logic [DATA_WIDTH-1:0]             s_byteFromRx,
    output logic                              tx_resend,
    output logic                              write_done,
    output logic [slave_pkg::STATUS_BITS-1:0] ack_status
);
    import slave_pkg::*;

    localparam int TMR_W    = $clog2(ACK_TIMEOUT + 1);
    localparam int LAUNCH_W = $clog2(RETRANSMIT_TIMES + 1);

    logic                waiting;
    logic [TMR_W-1:0]    timer;
    logic [LAUNCH_W-1:0] launches;
    logic                timed_out;
    logic                last_launch;
    logic                ack_seen;

    assign timed_out   = (timer == TMR_W'(ACK_TIMEOUT - 1));
    assign last_launch = (launches == LAUNCH_W'(RETRANSMIT_TIMES));
    // only the low byte carries the neighbour's answer
    assign ack_seen    = (s_byteFromRx[7:0] == ACK_BYTE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waiting    <= 1'b0;
            timer      <= '0;
            launches   <= '0;
            tx_resend  <= 1'b0;
            write_done <= 1'b0;
            ack_status <= '0;
        end else begin
            tx_resend  <= 1'b0;
            write_done <= 1'b0;
            if (s_txStart) begin
                waiting  <= 1'b1;
                timer    <= '0;
                launches <= launches + 1'b1;
            end else if (waiting) begin
                if (s_rxDone) begin
                    ack_status <= ack_seen ? ACK_NIBBLE : NAK_NIBBLE;
                    write_done <= 1'b1;
                    waiting    <= 1'b0;
                    launches   <= '0;
                end else if (timed_out) begin
                    waiting <= 1'b0;
                    timer   <= '0;
                    if (last_launch) begin
                        // no answer after all launches
                        ack_status <= NAK_NIBBLE;
                        write_done <= 1'b1;
                        launches   <= '0;
                    end else begin
                        tx_resend <= 1'b1;
                    end
                end else begin
                    timer <= timer + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: read_path.sv
`timescale 1ns/1ns
`default_nettype none

module read_path #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              read_en,
    input  logic                              g_rxDone,
    input  logic [DATA_WIDTH-1:0]             g_byteFromRx,
    input  logic                              g_txReady,
    input  logic [slave_pkg::STATUS_BITS-1:0] ack_status,
    output logic                              g_txStart,
    output logic [DATA_WIDTH-1:0]             g_byteForTx,
    output logic                              rD,
    output logic                              streaming,
    output logic                              read_done
);
    import slave_pkg::*;

    // status nibble followed by the data word
    localparam int STREAM_LEN = STATUS_BITS + DATA_WIDTH;
    localparam int CNT_W      = $clog2(STREAM_LEN);

    typedef enum logic [1:0] {
        PH_WAIT,
        PH_ACK,
        PH_STREAM
    } phase_t;

    phase_t                phase;
    logic [DATA_WIDTH-1:0] word_q;
    logic [STREAM_LEN-1:0] stream_sr;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  capture;
    logic                  last_bit;

    assign capture   = read_en && (phase == PH_WAIT) && g_rxDone;
    assign last_bit  = (bit_cnt == CNT_W'(STREAM_LEN - 1));
    assign g_txStart = (phase == PH_ACK) && g_txReady;
    assign streaming = (phase == PH_STREAM);
    assign read_done = streaming && last_bit;
    assign rD        = streaming && stream_sr[STREAM_LEN-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase   <= PH_WAIT;
            bit_cnt <= '0;
        end else if (!read_en) begin
            phase   <= PH_WAIT;
            bit_cnt <= '0;
        end else begin
            case (phase)
                PH_WAIT: if (g_rxDone) phase <= PH_ACK;
                PH_ACK: begin
                    if (g_txReady) begin
                        bit_cnt <= '0;
                        phase   <= PH_STREAM;
                    end
                end
                PH_STREAM: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit)
                        phase <= PH_WAIT;
                end
                default: phase <= PH_WAIT;
            endcase
        end
    end

    // capture the word and the ack byte that goes back to the previous board
    always_ff @(posedge clk) begin
        if (capture) begin
            word_q      <= g_byteFromRx;
            g_byteForTx <= DATA_WIDTH'(ACK_BYTE);
        end
        if (g_txStart)
            stream_sr <= {ack_status, word_q};
        else if (streaming)
            stream_sr <= stream_sr << 1;
    end

endmodule

`default_nettype wire

// File: uart_bus_slave.sv
`timescale 1ns/1ns
`default_nettype none

module uart_bus_slave #(
    parameter int DATA_WIDTH       = 32,
    parameter int ID_WIDTH         = 2,
    parameter int SLAVE_ID         = 1,
    parameter int ACK_TIMEOUT      = 10000,
    parameter int RETRANSMIT_TIMES = 3
) (
    input  logic                  clk,
    input  logic                  rstN,
    // master port
    input  logic                  control,
    input  logic                  wD,
    input  logic                  valid,
    output logic                  rD,
    output logic                  ready,
    // send-side uart
    output logic                  s_txStart,
    output logic [DATA_WIDTH-1:0] s_byteForTx,
    input  logic                  s_txReady,
    input  logic                  s_rxDone,
    input  logic [DATA_WIDTH-1:0] s_byteFromRx,
    // get-side uart
    output logic                  g_txStart,
    output logic [DATA_WIDTH-1:0] g_byteForTx,
    input  logic                  g_txReady,
    input  logic                  g_rxDone,
    input  logic [DATA_WIDTH-1:0] g_byteFromRx
);
    logic       write_en;
    logic       read_en;
    logic       word_full;
    logic       streaming;
    logic       tx_resend;
    logic       write_done;
    logic       read_done;
    logic [3:0] ack_status;

    slave_sequencer #(
        .ID_WIDTH (ID_WIDTH),
        .SLAVE_ID (SLAVE_ID)
    ) u_sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .word_full  (word_full),
        .streaming  (streaming),
        .write_done (write_done),
        .read_done  (read_done),
        .ready      (ready),
        .write_en   (write_en),
        .read_en    (read_en)
    );

    write_path #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_write_path (
        .clk         (clk),
        .rstN        (rstN),
        .write_en    (write_en),
        .wD          (wD),
        .valid       (valid),
        .s_txReady   (s_txReady),
        .tx_resend   (tx_resend),
        .s_txStart   (s_txStart),
        .s_byteForTx (s_byteForTx),
        .word_full   (word_full)
    );

    ack_tracker #(
        .DATA_WIDTH       (DATA_WIDTH),
        .ACK_TIMEOUT      (ACK_TIMEOUT),
        .RETRANSMIT_TIMES (RETRANSMIT_TIMES)
    ) u_ack_tracker (
        .clk          (clk),
        .rstN         (rstN),
        .s_txStart    (s_txStart),
        .s_rxDone     (s_rxDone),
        .s_byteFromRx (s_byteFromRx),
        .tx_resend    (tx_resend),
        .write_done   (write_done),
        .ack_status   (ack_status)
    );

    read_path #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_read_path (
        .clk          (clk),
        .rstN         (rstN),
        .read_en      (read_en),
        .g_rxDone     (g_rxDone),
        .g_byteFromRx (g_byteFromRx),
        .g_txReady    (g_txReady),
        .ack_status   (ack_status),
        .g_txStart    (g_txStart),
        .g_byteForTx  (g_byteForTx),
        .rD           (rD),
        .streaming    (streaming),
        .read_done    (read_done)
    );

endmodule

`default_nettype wire

// File: tb_uart_bus_slave.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_bus_slave;
    import slave_pkg::*;

    localparam int DW         = 16;
    localparam int ID_W       = 2;
    localparam int SLAVE_ID   = 1;
    localparam int TIMEOUT    = 20;
    localparam int RETRIES    = 3;
    localparam int FRAME_LEN  = 3 + ID_W + 1;
    localparam int NUM_TRANS  = 200;
    localparam int MAX_CYCLES = NUM_TRANS * (DW + 4 * TIMEOUT + 64);

    logic          clk;
    logic          rstN;
    logic          control;
    logic          wD;
    logic          valid;
    logic          rD;
    logic          ready;
    logic          s_txStart;
    logic [DW-1:0] s_byteForTx;
    logic          s_txReady;
    logic          s_rxDone;
    logic [DW-1:0] s_byteFromRx;
    logic          g_txStart;
    logic [DW-1:0] g_byteForTx;
    logic          g_txReady;
    logic          g_rxDone;
    logic [DW-1:0] g_byteFromRx;

    logic [31:0] lfsr = 32'hfe63;
    int          cycle_cnt = 0;
    // status the slave should report on the next read
    logic [3:0]  model_status;

    uart_bus_slave #(
        .DATA_WIDTH       (DW),
        .ID_WIDTH         (ID_W),
        .SLAVE_ID         (SLAVE_ID),
        .ACK_TIMEOUT      (TIMEOUT),
        .RETRANSMIT_TIMES (RETRIES)
    ) dut (
        .clk          (clk),
        .rstN         (rstN),
        .control      (control),
        .wD           (wD),
        .valid        (valid),
        .rD           (rD),
        .ready        (ready),
        .s_txStart    (s_txStart),
        .s_byteForTx  (s_byteForTx),
        .s_txReady    (s_txReady),
        .s_rxDone     (s_rxDone),
        .s_byteFromRx (s_byteFromRx),
        .g_txStart    (g_txStart),
        .g_byteForTx  (g_byteForTx),
        .g_txReady    (g_txReady),
        .g_rxDone     (g_rxDone),
        .g_byteFromRx (g_byteFromRx)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string what);
        $display("failure: %s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES)
            fail_run("timeout, the test did not finish within the cycle limit");
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // the uart peer moves its ready levels and drops its pulses on each rising edge
    task automatic next_edge();
        @(posedge clk);
        s_txReady <= (rand_bits(2) != 0);
        g_txReady <= (rand_bits(2) != 0);
        s_rxDone  <= 1'b0;
        g_rxDone  <= 1'b0;
    endtask

    task automatic idle_checks(input logic exp_ready);
        compare_values("ready", 32'(ready), 32'(exp_ready));
        compare_values("s_txStart", 32'(s_txStart), 32'd0);
        compare_values("g_txStart", 32'(g_txStart), 32'd0);
    endtask

    // start code, id msb first, direction
    task automatic send_frame(input logic [2:0] code, input logic [ID_W-1:0] id,
                              input logic dir, input logic ready_after);
        logic [FRAME_LEN-1:0] bits;
        bits = {code, id, dir};
        for (int i = FRAME_LEN - 1; i >= 0; i--) begin
            next_edge();
            control <= bits[i];
            @(negedge clk);
            idle_checks(1'b1);
        end
        next_edge();
        control <= 1'b0;
        @(negedge clk);
        compare_values("ready", 32'(ready), 32'(ready_after));
    endtask

    task automatic reject_frame();
        logic [2:0]      code;
        logic [ID_W-1:0] id;
        code = START_CODE;
        id   = ID_W'(SLAVE_ID);
        // first bit stays high so the frame really opens
        if (rand_bits(1) != 0) begin
            code = {1'b1, 2'(rand_bits(2))};
            if (code == START_CODE)
                code = 3'b101;
        end else begin
            id = ID_W'(rand_bits(ID_W));
            if (id == ID_W'(SLAVE_ID))
                id = ~id;
        end
        send_frame(code, id, rand_bits(1) != 0, 1'b1);
        // a wrongly accepted write would fill its word here
        for (int i = 0; i < DW + 2; i++) begin
            next_edge();
            valid <= 1'b1;
            wD    <= (rand_bits(1) != 0);
            @(negedge clk);
            idle_checks(1'b1);
        end
        next_edge();
        valid <= 1'b0;
        @(negedge clk);
        idle_checks(1'b1);
    endtask

    task automatic write_word();
        logic [DW-1:0] word;
        logic [DW-1:0] reply;
        logic [7:0]    nak;
        logic [1:0]    choice;
        logic          v;
        logic          b;
        logic          answered;
        int            taken;
        int            launches;
        int            reply_wait;
        word       = '0;
        reply      = '0;
        answered   = 1'b0;
        taken      = 0;
        launches   = 0;
        reply_wait = 0;
        send_frame(START_CODE, ID_W'(SLAVE_ID), 1'b1, 1'b1);
        // master bits with random valid gaps
        while (taken < DW) begin
            next_edge();
            v = (rand_bits(2) != 0);
            b = (rand_bits(1) != 0);
            valid <= v;
            wD    <= b;
            if (v) begin
                word  = {word[DW-2:0], b};
                taken = taken + 1;
            end
            @(negedge clk);
            idle_checks(1'b1);
        end
        next_edge();
        valid <= 1'b0;
        @(negedge clk);
        compare_values("ready", 32'(ready), 32'd0);
        while (ready == 1'b0) begin
            if (s_txStart) begin
                compare_values("s_txReady", 32'(s_txReady), 32'd1);
                compare_values("s_byteForTx", 32'(s_byteForTx), 32'(word));
                if (answered || launches == RETRIES)
                    fail_run("s_txStart pulsed after the write should have ended");
                launches = launches + 1;
                // 0 ack, 1 other byte, otherwise the peer stays silent
                choice = 2'(rand_bits(2));
                if (choice < 2) begin
                    answered   = 1'b1;
                    reply_wait = 1 + int'(rand_bits(4));
                    nak        = 8'(rand_bits(8));
                    if (nak == ACK_BYTE)
                        nak = NAK_BYTE;
                    reply        = (choice == 0) ? DW'(ACK_BYTE) : DW'(nak);
                    model_status = (choice == 0) ? ACK_NIBBLE : NAK_NIBBLE;
                end
            end
            next_edge();
            if (reply_wait > 0) begin
                reply_wait = reply_wait - 1;
                if (reply_wait == 0) begin
                    s_rxDone     <= 1'b1;
                    s_byteFromRx <= reply;
                end
            end
            @(negedge clk);
        end
        if (answered) begin
            compare_values("pending reply", 32'(reply_wait), 32'd0);
        end else begin
            compare_values("s_txStart count", 32'(launches), 32'(RETRIES));
            model_status = NAK_NIBBLE;
        end
    endtask

    task automatic read_word();
        logic [DW-1:0] word;
        logic [DW+3:0] exp_stream;
        int            gap;
        send_frame(START_CODE, ID_W'(SLAVE_ID), 1'b0, 1'b0);
        gap = int'(rand_bits(3));
        for (int i = 0; i < gap; i++) begin
            next_edge();
            @(negedge clk);
            idle_checks(1'b0);
        end
        word = DW'(rand_bits(DW));
        next_edge();
        g_rxDone     <= 1'b1;
        g_byteFromRx <= word;
        @(negedge clk);
        idle_checks(1'b0);
        do begin
            next_edge();
            @(negedge clk);
            compare_values("ready", 32'(ready), 32'd0);
        end while (!g_txStart);
        compare_values("g_txReady", 32'(g_txReady), 32'd1);
        compare_values("g_byteForTx", 32'(g_byteForTx), 32'(ACK_BYTE));
        exp_stream = {model_status, word};
        for (int i = DW + 3; i >= 0; i--) begin
            next_edge();
            @(negedge clk);
            compare_values("ready", 32'(ready), 32'd1);
            compare_values("rD", 32'(rD), 32'(exp_stream[i]));
        end
        next_edge();
        @(negedge clk);
        compare_values("ready", 32'(ready), 32'd0);
        next_edge();
        @(negedge clk);
        compare_values("ready", 32'(ready), 32'd1);
    endtask

    initial begin
        logic [1:0] kind;
        clk          = 1'b0;
        model_status = '0;
        rstN         <= 1'b0;
        control      <= 1'b0;
        wD           <= 1'b0;
        valid        <= 1'b0;
        s_txReady    <= 1'b0;
        s_rxDone     <= 1'b0;
        s_byteFromRx <= '0;
        g_txReady    <= 1'b0;
        g_rxDone     <= 1'b0;
        g_byteFromRx <= '0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        idle_checks(1'b1);
        for (int t = 0; t < NUM_TRANS; t++) begin
            kind = 2'(rand_bits(2));
            case (kind)
                2'd0:    reject_frame();
                2'd1:    read_word();
                default: write_word();
            endcase
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
slave_pkg.sv
slave_sequencer.sv
write_path.sv
ack_tracker.sv
read_path.sv
uart_bus_slave.sv
tb_uart_bus_slave.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, then search the log for the fail message
rm -f sim.log
verilator --binary --timing --top-module tb_uart_bus_slave -f compile.f -o sim_tb \
    && { ./obj_dir/sim_tb > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "ERRORS FOUND" sim.log \
    && grep -q "NO ERRORS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
